// File: logic/bus_pkg.sv
// system bus definitions

package bus_pkg;

	// --------------------
	// bus words
	// --------------------

	// bus bits counted from the left
	// bit 0 is the msb
	localparam int BUS_WORD_W = 16;
	localparam int BUS_NB_W = 4;

	// one word on ad, dt or rdt
	typedef logic [0:BUS_WORD_W-1] bus_word_t;

	// block number above the 16-bit address
	typedef logic [0:BUS_NB_W-1] bus_nb_t;

	// --------------------
	// cycle kinds
	// --------------------

	// latched from the strobes at the start of a cycle
	// s has priority over w and w over r
	typedef enum logic [1:0] {
		// memory read on r
		CMD_READ = 2'd0,
		// memory write on w
		CMD_WRITE = 2'd1,
		// one segment-map entry on s
		CMD_CONFIG = 2'd2
	} bus_cmd_e;

	// parity, en/pe replies and reservation lines not modelled
	// only w, r and s strobes with the ok answer exist here

endpackage

// File: logic/mem_pkg.sv
// memory organization

package mem_pkg;

	import bus_pkg::*;

	// --------------------
	// segments
	// --------------------

	// in-segment address bits for 4K-word segments
	localparam int SEG_SHIFT = 12;

	// one entry per block number and segment
	localparam int MAP_IDX_W = 8;
	localparam int MAP_DEPTH = 1 << MAP_IDX_W;

	// --------------------
	// config word
	// --------------------

	// dt seen during an s cycle
	typedef struct packed {
		logic en;
		logic [1:7] rsvd;
		logic [0:7] frame;
	} mem_cfg_t;

	// dt is data on w and a map entry on s
	typedef union packed {
		bus_word_t word;
		mem_cfg_t cfg;
	} mem_word_u;

	// --------------------
	// map storage
	// --------------------

	// frame only partly used depending on sram size
	typedef struct packed {
		logic en;
		logic [0:7] frame;
	} map_entry_t;

endpackage

// File: logic/power_clear.sv
// memory clear sequencer

`timescale 1ns/1ps

module power_clear #(
	parameter int CLM_TICKS = 8
)(
	input logic clk_sys,
	input logic rst,
	input logic dcl,
	output logic clm
);

	// counter wide enough to hold CLM_TICKS
	localparam int CNT_W = $clog2(CLM_TICKS + 1);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(CLM_TICKS);

	logic [CNT_W-1:0] cnt;

	// --------------------
	// clear counter
	// --------------------

	// reload on reset or panel clear
	// then count down to zero
	always_ff @(posedge clk_sys) begin
		if (rst || dcl) begin
			cnt <= CNT_LOAD;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// --------------------
	// clear pulse
	// --------------------

	// high from the cycle after rst/dcl
	// lasts CLM_TICKS cycles past the last one
	assign clm = (cnt != '0);

endmodule

// File: logic/bus_receiver.sv
// system bus receiver

`timescale 1ns/1ps

module bus_receiver
	import bus_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input logic clm,
	// system bus
	input logic w,
	input logic r,
	input logic s,
	input bus_nb_t nb,
	input bus_word_t ad,
	input bus_word_t dt,
	output logic ok,
	// to segment map
	output logic cmd_req,
	output bus_cmd_e cmd_kind,
	output bus_nb_t cmd_nb,
	output bus_word_t cmd_ad,
	output bus_word_t cmd_dt,
	input logic cmd_ack,
	input logic cmd_miss
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUSY = 2'd1;
	localparam logic [1:0] ST_ANSWER = 2'd2;
	localparam logic [1:0] ST_RELEASE = 2'd3;

	logic [1:0] state;
	logic strobe;

	// any strobe starts a cycle
	assign strobe = s | w | r;

	// --------------------
	// cycle payload
	// --------------------

	// latched once per cycle and held until the next one
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && strobe && !clm && !cmd_ack) begin
			// priority s, w, r
			if (s) begin
				cmd_kind <= CMD_CONFIG;
			end else if (w) begin
				cmd_kind <= CMD_WRITE;
			end else begin
				cmd_kind <= CMD_READ;
			end
			cmd_nb <= nb;
			cmd_ad <= ad;
			cmd_dt <= dt;
		end
	end

	// --------------------
	// handshake FSM
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= ST_IDLE;
			cmd_req <= 1'b0;
			ok <= 1'b0;
		end else begin
			case (state)
				// strobes ignored during memory clear
				// previous ack must be gone too
				ST_IDLE: begin
					if (strobe && !clm && !cmd_ack) begin
						cmd_req <= 1'b1;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						if (cmd_miss) begin
							// unmapped so the master times out on its own
							state <= ST_RELEASE;
						end else begin
							ok <= 1'b1;
							state <= ST_ANSWER;
						end
					end
				end
				// ok held as long as the master holds its strobe
				ST_ANSWER: begin
					if (!strobe) begin
						ok <= 1'b0;
						state <= ST_IDLE;
					end
				end
				// silent until the strobe is released
				ST_RELEASE: begin
					if (!strobe) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/seg_map.sv
// segment map and address translation

`timescale 1ns/1ps

module seg_map
	import bus_pkg::*;
	import mem_pkg::*;
#(
	parameter int SRAM_AW = 16
)(
	input logic clk_sys,
	input logic rst,
	input logic clm,
	// from bus receiver
	input logic cmd_req,
	input bus_cmd_e cmd_kind,
	input bus_nb_t cmd_nb,
	input bus_word_t cmd_ad,
	input bus_word_t cmd_dt,
	output logic cmd_ack,
	output logic cmd_miss,
	// to sram sequencer
	output logic acc_req,
	output logic acc_write,
	output logic [SRAM_AW-1:0] acc_addr,
	output bus_word_t acc_wdata,
	input logic acc_ack
);

	// usable frame bits for this sram size
	localparam int FRAME_W = SRAM_AW - SEG_SHIFT;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FWD = 2'd1;
	localparam logic [1:0] ST_ACK = 2'd2;

	logic [1:0] state;
	map_entry_t map_mem [MAP_DEPTH];
	logic [MAP_IDX_W-1:0] idx;
	map_entry_t entry;
	mem_word_u cfg_word;
	logic [7:0] frame_bits;
	logic accept;

	// block number then top four address bits
	assign idx = {cmd_nb, cmd_ad[0:3]};
	assign entry = map_mem[idx];
	assign cfg_word.word = cmd_dt;
	assign frame_bits = entry.frame;
	assign accept = (state == ST_IDLE) && cmd_req && !acc_ack;

	// --------------------
	// map storage
	// --------------------

	// clm drops every enable and leaves the frames
	always_ff @(posedge clk_sys) begin
		if (clm) begin
			for (int i = 0; i < MAP_DEPTH; i++) begin
				map_mem[i].en <= 1'b0;
			end
		end else if (accept && cmd_kind == CMD_CONFIG) begin
			map_mem[idx].en <= cfg_word.cfg.en;
			map_mem[idx].frame <= cfg_word.cfg.frame;
		end
	end

	// physical address is frame then in-segment offset
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			acc_write <= (cmd_kind == CMD_WRITE);
			acc_addr <= {frame_bits[FRAME_W-1:0], cmd_ad[4:15]};
			acc_wdata <= cmd_dt;
		end
	end

	// --------------------
	// request FSM
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= ST_IDLE;
			cmd_ack <= 1'b0;
			cmd_miss <= 1'b0;
			acc_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (cmd_kind == CMD_CONFIG) begin
							// config answered right away
							cmd_ack <= 1'b1;
							cmd_miss <= 1'b0;
							state <= ST_ACK;
						end else if (!entry.en) begin
							cmd_ack <= 1'b1;
							cmd_miss <= 1'b1;
							state <= ST_ACK;
						end else begin
							acc_req <= 1'b1;
							state <= ST_FWD;
						end
					end
				end
				// sram done so the ack goes back
				ST_FWD: begin
					if (acc_ack) begin
						acc_req <= 1'b0;
						cmd_ack <= 1'b1;
						cmd_miss <= 1'b0;
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						cmd_miss <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/sram_sequencer.sv
// sram access sequencer

`timescale 1ns/1ps

module sram_sequencer
	import bus_pkg::*;
#(
	parameter int SRAM_AW = 16
)(
	input logic clk_sys,
	input logic rst,
	// from segment map
	input logic acc_req,
	input logic acc_write,
	input logic [SRAM_AW-1:0] acc_addr,
	input bus_word_t acc_wdata,
	output logic acc_ack,
	// last word read goes out on the bus
	output bus_word_t rdt,
	// sram pins
	output logic sram_ce,
	output logic sram_we,
	output logic [SRAM_AW-1:0] sram_a,
	output bus_word_t sram_wdata,
	input bus_word_t sram_rdata
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_STROBE = 2'd1;
	localparam logic [1:0] ST_CAPTURE = 2'd2;

	logic [1:0] state;
	// read still waiting for its data word
	logic rd_pend;

	// --------------------
	// sram pins
	// --------------------

	// address and data follow the request
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && acc_req && !acc_ack) begin
			sram_a <= acc_addr;
			sram_wdata <= acc_wdata;
		end
	end

	// --------------------
	// read data
	// --------------------

	// sram answers one cycle after the strobe
	// rdt keeps the word until the next read
	always_ff @(posedge clk_sys) begin
		if (state == ST_CAPTURE && rd_pend) begin
			rdt <= sram_rdata;
		end
	end

	// --------------------
	// sequencer FSM
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= ST_IDLE;
			sram_ce <= 1'b0;
			sram_we <= 1'b0;
			acc_ack <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			case (state)
				// new work only once the old ack is gone
				ST_IDLE: begin
					if (acc_req && !acc_ack) begin
						sram_ce <= 1'b1;
						sram_we <= acc_write;
						rd_pend <= !acc_write;
						state <= ST_STROBE;
					end
				end
				// one-cycle strobe with the ack raised here
				ST_STROBE: begin
					sram_ce <= 1'b0;
					sram_we <= 1'b0;
					acc_ack <= 1'b1;
					state <= ST_CAPTURE;
				end
				// data taken on the first cycle
				// ack held until request drops
				ST_CAPTURE: begin
					rd_pend <= 1'b0;
					if (!acc_req) begin
						acc_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// timing seen from the map side
	// pins driven the cycle after acc_req is sampled
	// ack two cycles after the request
	// rdt valid one cycle after that

endmodule

// File: logic/mera_mem.sv
// MERA-400 memory module

`timescale 1ns/1ps

module mera_mem
	import bus_pkg::*;
#(
	parameter int SRAM_AW = 16,
	parameter int CLM_TICKS = 8
)(
	input logic clk_sys,
	input logic rst,
	// panel clear
	input logic dcl,
	// system bus
	input logic w,
	input logic r,
	input logic s,
	input bus_nb_t nb,
	input bus_word_t ad,
	input bus_word_t dt,
	output logic ok,
	output bus_word_t rdt,
	// memory clear pulse
	output logic clm,
	// sram
	output logic sram_ce,
	output logic sram_we,
	output logic [SRAM_AW-1:0] sram_a,
	output bus_word_t sram_wdata,
	input bus_word_t sram_rdata
);

	// --------------------
	// clear
	// --------------------

	power_clear #(
		.CLM_TICKS(CLM_TICKS)
	) pwr(
		.clk_sys(clk_sys),
		.rst(rst),
		.dcl(dcl),
		.clm(clm)
	);

	// --------------------
	// bus side
	// --------------------

	// receiver to segment map
	logic cmd_req;
	bus_cmd_e cmd_kind;
	bus_nb_t cmd_nb;
	bus_word_t cmd_ad;
	bus_word_t cmd_dt;
	logic cmd_ack;
	logic cmd_miss;

	bus_receiver rx(
		.clk_sys(clk_sys),
		.rst(rst),
		.clm(clm),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt(dt),
		.ok(ok),
		.cmd_req(cmd_req),
		.cmd_kind(cmd_kind),
		.cmd_nb(cmd_nb),
		.cmd_ad(cmd_ad),
		.cmd_dt(cmd_dt),
		.cmd_ack(cmd_ack),
		.cmd_miss(cmd_miss)
	);

	// --------------------
	// segment map
	// --------------------

	// segment map to sram sequencer
	logic acc_req;
	logic acc_write;
	logic [SRAM_AW-1:0] acc_addr;
	bus_word_t acc_wdata;
	logic acc_ack;

	seg_map #(
		.SRAM_AW(SRAM_AW)
	) map(
		.clk_sys(clk_sys),
		.rst(rst),
		.clm(clm),
		.cmd_req(cmd_req),
		.cmd_kind(cmd_kind),
		.cmd_nb(cmd_nb),
		.cmd_ad(cmd_ad),
		.cmd_dt(cmd_dt),
		.cmd_ack(cmd_ack),
		.cmd_miss(cmd_miss),
		.acc_req(acc_req),
		.acc_write(acc_write),
		.acc_addr(acc_addr),
		.acc_wdata(acc_wdata),
		.acc_ack(acc_ack)
	);

	// --------------------
	// sram side
	// --------------------

	sram_sequencer #(
		.SRAM_AW(SRAM_AW)
	) seq(
		.clk_sys(clk_sys),
		.rst(rst),
		.acc_req(acc_req),
		.acc_write(acc_write),
		.acc_addr(acc_addr),
		.acc_wdata(acc_wdata),
		.acc_ack(acc_ack),
		.rdt(rdt),
		.sram_ce(sram_ce),
		.sram_we(sram_we),
		.sram_a(sram_a),
		.sram_wdata(sram_wdata),
		.sram_rdata(sram_rdata)
	);

endmodule

// File: testbench/tb_tasks.svh
// bus cycles and directed tests

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	// --------------------
	// compare
	// --------------------

	task automatic check_word(input string name, input bus_word_t got,
			input bus_word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// --------------------
	// reference model
	// --------------------

	// fibonacci with taps 16 14 13 11
	// one step per bit
	function automatic logic [15:0] lfsr_bits(input int count);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// block number then top address nibble
	function automatic logic [7:0] map_index(input bus_nb_t b, input bus_word_t a);
		return {b, a[0:3]};
	endfunction

	// frame cut to the sram size then offset
	function automatic logic [SRAM_AW-1:0] phys_addr(input logic [7:0] frame,
			input bus_word_t a);
		return {frame[FRAME_W-1:0], a[4:15]};
	endfunction

	// clm empties the whole map
	function automatic void forget_map();
		for (int i = 0; i < 256; i++) begin
			map_frame_m[i] = 8'h00;
		end
	endfunction

	// --------------------
	// bus master
	// --------------------

	task automatic apply_reset();
		rst <= 1'b1;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		forget_map();
	endtask

	// cycles with clm high from the next falling edge
	task automatic measure_clear(output int ticks);
		logic done;
		ticks = 0;
		done = 1'b0;
		for (int n = 0; n < CLEAR_TIMEOUT && !done; n++) begin
			@(negedge clk_sys);
			if (clm) begin
				ticks++;
			end else begin
				done = 1'b1;
			end
		end
		if (!done) begin
			abort_run("clm stayed high, the memory clear never ended");
		end
	endtask

	// one strobe answered by ok or silence
	task automatic bus_cycle(input bus_cmd_e kind, input bus_nb_t cyc_nb,
			input bus_word_t cyc_ad, input bus_word_t cyc_dt,
			output logic got_ok, output bus_word_t rd_word);
		logic released;
		got_ok = 1'b0;
		rd_word = '0;
		released = 1'b0;
		@(posedge clk_sys);
		nb <= cyc_nb;
		ad <= cyc_ad;
		dt <= cyc_dt;
		case (kind)
			CMD_CONFIG: s <= 1'b1;
			CMD_WRITE: w <= 1'b1;
			default: r <= 1'b1;
		endcase
		// rdt valid while ok answers a read
		for (int n = 0; n < OK_TIMEOUT && !got_ok; n++) begin
			@(negedge clk_sys);
			if (ok) begin
				got_ok = 1'b1;
				rd_word = rdt;
			end
		end
		// master drops the strobe itself on a miss
		@(posedge clk_sys);
		s <= 1'b0;
		w <= 1'b0;
		r <= 1'b0;
		if (got_ok) begin
			for (int n = 0; n < OK_TIMEOUT && !released; n++) begin
				@(negedge clk_sys);
				released = !ok;
			end
			if (!released) begin
				abort_run("ok stayed high after the strobe was dropped");
			end
		end
	endtask

	task automatic config_entry(input bus_nb_t b, input logic [3:0] seg,
			input logic [7:0] frame, input logic en);
		bus_word_t a;
		bus_word_t cfg;
		logic got;
		bus_word_t word;
		a = {seg, 12'h000};
		// enable in bit 0 and frame in bits 8 to 15
		cfg = '0;
		cfg[0] = en;
		cfg[8:15] = frame;
		bus_cycle(CMD_CONFIG, b, a, cfg, got, word);
		check_bit($sformatf("ok config nb=%h seg=%h", b, seg), got, 1'b1);
		map_frame_m[map_index(b, a)] = frame;
	endtask

	task automatic write_word(input bus_nb_t b, input bus_word_t a,
			input bus_word_t data, input logic expect_ok);
		logic got;
		bus_word_t word;
		bus_cycle(CMD_WRITE, b, a, data, got, word);
		check_bit($sformatf("ok write nb=%h ad=%h", b, a), got, expect_ok);
		if (expect_ok) begin
			ref_mem[phys_addr(map_frame_m[map_index(b, a)], a)] = data;
		end
	endtask

	task automatic read_word(input bus_nb_t b, input bus_word_t a, input logic expect_ok);
		logic got;
		bus_word_t word;
		bus_word_t want;
		want = ref_mem[phys_addr(map_frame_m[map_index(b, a)], a)];
		bus_cycle(CMD_READ, b, a, '0, got, word);
		check_bit($sformatf("ok read nb=%h ad=%h", b, a), got, expect_ok);
		if (expect_ok) begin
			check_word($sformatf("rdt nb=%h ad=%h", b, a), word, want);
		end
	endtask

	// --------------------
	// directed tests
	// --------------------

	task automatic clear_after_reset();
		int ticks;
		measure_clear(ticks);
		compare_count("clm cycles after reset", ticks, CLM_TICKS);
		check_bit("ok after reset", ok, 1'b0);
		// nobody answers with an empty map
		read_word(4'h0, 16'h0000, 1'b0);
		read_word(4'h2, 16'h5123, 1'b0);
	endtask

	task automatic map_and_access();
		config_entry(4'h2, 4'h5, 8'h03, 1'b1);
		write_word(4'h2, 16'h5123, 16'hbeef, 1'b1);
		read_word(4'h2, 16'h5123, 1'b1);
	endtask

	// two segments on frame 7 and one on frame 9
	task automatic segment_alias();
		config_entry(4'h4, 4'h1, 8'h07, 1'b1);
		config_entry(4'h6, 4'h9, 8'h07, 1'b1);
		config_entry(4'h4, 4'h2, 8'h09, 1'b1);
		write_word(4'h4, 16'h22a0, 16'h0f0f, 1'b1);
		write_word(4'h4, 16'h12a0, 16'h1234, 1'b1);
		read_word(4'h6, 16'h92a0, 1'b1);
		read_word(4'h4, 16'h22a0, 1'b1);
		write_word(4'h6, 16'h92a1, 16'habcd, 1'b1);
		read_word(4'h4, 16'h12a1, 1'b1);
	endtask

	task automatic entry_removal();
		config_entry(4'h6, 4'h9, 8'h07, 1'b0);
		read_word(4'h6, 16'h92a0, 1'b0);
		write_word(4'h6, 16'h92a0, 16'hdead, 1'b0);
		// frame 7 unchanged through the other alias
		read_word(4'h4, 16'h12a0, 1'b1);
		read_word(4'h4, 16'h22a0, 1'b1);
		read_word(4'h2, 16'h5123, 1'b1);
	endtask

	task automatic panel_clear();
		int ticks;
		@(posedge clk_sys);
		dcl <= 1'b1;
		@(posedge clk_sys);
		dcl <= 1'b0;
		measure_clear(ticks);
		compare_count("clm cycles after dcl", ticks, CLM_TICKS);
		forget_map();
		read_word(4'h2, 16'h5123, 1'b0);
		read_word(4'h4, 16'h12a0, 1'b0);
		write_word(4'h4, 16'h22a0, 16'h7777, 1'b0);
		// sram keeps its data so remap brings it back
		config_entry(4'h2, 4'h5, 8'h03, 1'b1);
		read_word(4'h2, 16'h5123, 1'b1);
	endtask

	task automatic random_traffic();
		bus_nb_t seg_nb [4];
		logic [3:0] seg_id [4];
		logic [7:0] seg_frame [4];
		bus_nb_t pick_nb [16];
		bus_word_t pick_ad [16];
		bus_word_t pick_dt [16];
		logic [1:0] sel;
		logic [15:0] rnd;
		int j;
		seg_nb[0] = 4'h1;
		seg_nb[1] = 4'h5;
		seg_nb[2] = 4'h7;
		seg_nb[3] = 4'hf;
		seg_id[0] = 4'h3;
		seg_id[1] = 4'h0;
		seg_id[2] = 4'hf;
		seg_id[3] = 4'h8;
		seg_frame[0] = 8'h0a;
		seg_frame[1] = 8'h0b;
		seg_frame[2] = 8'h0c;
		// upper frame bits beyond the sram get masked
		seg_frame[3] = 8'h1d;
		for (int k = 0; k < 4; k++) begin
			config_entry(seg_nb[k], seg_id[k], seg_frame[k], 1'b1);
		end
		for (int i = 0; i < 16; i++) begin
			rnd = lfsr_bits(2);
			sel = rnd[1:0];
			rnd = lfsr_bits(12);
			pick_nb[i] = seg_nb[sel];
			pick_ad[i] = {seg_id[sel], rnd[11:0]};
			pick_dt[i] = lfsr_bits(16);
			write_word(pick_nb[i], pick_ad[i], pick_dt[i], 1'b1);
		end
		// scattered read order
		for (int i = 0; i < 16; i++) begin
			j = (i * 7 + 3) % 16;
			read_word(pick_nb[j], pick_ad[j], 1'b1);
		end
	endtask

`endif

// File: testbench/tb_mera_mem.sv
// memory module testbench

`timescale 1ns/1ps

module tb_mera_mem
	import bus_pkg::*;
();

	localparam int SRAM_AW = 16;
	localparam int CLM_TICKS = 8;
	// in-segment bits
	// the rest of the sram address is frame
	localparam int OFFSET_W = 12;
	localparam int FRAME_W = SRAM_AW - OFFSET_W;
	// cycle limits for every wait
	localparam int OK_TIMEOUT = 64;
	localparam int CLEAR_TIMEOUT = 4 * CLM_TICKS + 16;

	logic clk_sys;
	logic rst;
	logic dcl;
	logic w;
	logic r;
	logic s;
	bus_nb_t nb;
	bus_word_t ad;
	bus_word_t dt;
	logic ok;
	bus_word_t rdt;
	logic clm;
	logic sram_ce;
	logic sram_we;
	logic [SRAM_AW-1:0] sram_a;
	bus_word_t sram_wdata;
	bus_word_t sram_rdata = '0;

	// sram contents
	bus_word_t sram_mem [1 << SRAM_AW];
	// expected image by frame and offset
	bus_word_t ref_mem [1 << SRAM_AW];
	// segment frames as the master wrote them
	logic [7:0] map_frame_m [256];
	// random source
	logic [15:0] lfsr_state = 16'd27;

	// --------------------
	// clock and dut
	// --------------------

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	mera_mem #(
		.SRAM_AW(SRAM_AW),
		.CLM_TICKS(CLM_TICKS)
	) dut_i (
		.clk_sys(clk_sys),
		.rst(rst),
		.dcl(dcl),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt(dt),
		.ok(ok),
		.rdt(rdt),
		.clm(clm),
		.sram_ce(sram_ce),
		.sram_we(sram_we),
		.sram_a(sram_a),
		.sram_wdata(sram_wdata),
		.sram_rdata(sram_rdata)
	);

	// --------------------
	// sram model
	// --------------------

	// read data registered one cycle after ce
	always @(posedge clk_sys) begin
		if (sram_ce) begin
			if (sram_we) begin
				sram_mem[sram_a] <= sram_wdata;
			end else begin
				sram_rdata <= sram_mem[sram_a];
			end
		end
	end

	// first error ends the run
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_tasks.svh"

	// --------------------
	// test order
	// --------------------

	initial begin
		rst <= 1'b1;
		dcl <= 1'b0;
		w <= 1'b0;
		r <= 1'b0;
		s <= 1'b0;
		nb <= '0;
		ad <= '0;
		dt <= '0;
		forget_map();
		apply_reset();
		clear_after_reset();
		map_and_access();
		segment_alias();
		entry_removal();
		panel_clear();
		random_traffic();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+testbench
logic/bus_pkg.sv
logic/mem_pkg.sv
logic/power_clear.sv
logic/bus_receiver.sv
logic/seg_map.sv
logic/sram_sequencer.sv
logic/mera_mem.sv
testbench/tb_mera_mem.sv

// File: sim.sh
#!/usr/bin/env bash
# compile and run the memory testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--timescale 1ns/1ps \
	-f vlog.f \
	--top-module tb_mera_mem \
	-Mdir obj_dir \
	-o sim_mera_mem

# the verdict comes from the printed result below
sim_output=$(./obj_dir/sim_mera_mem 2>&1) || true
echo "$sim_output"

if grep -q "Simulation passed" <<< "$sim_output"; then
	exit 0
else
	exit 1
fi
